//--- Makefile
# Verilator build and run of the bridge testbench

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= rvfiRvviBridge_tb
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass message not found in $(LOG)"; exit 1; }
	@echo "PASS: simulation log $(LOG)"

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/rvfiRvviBridge_assertions.sv
// bound port checks: irq mask, csr flag timing, halt release, nmi cause hold
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module rvfiRvviBridge_assertions (
   input logic                     rvvi,
   input logic                     rstN_i,
   input logic                     retireValid_i,
   input logic [`RVVI_NUM_CSR-1:0] csrWb_i,
   input rvviTracePkg::irqVec_t    irqLevel_i,
   input logic                     haltReq_i,
   input logic                     nmi_i,
   input rvviTracePkg::intrCause_t nmiCause_i
);

   // unimplemented interrupt bits stay low
   irqMaskHeld: assert property (@(posedge rvvi) disable iff (!rstN_i)
      (irqLevel_i & ~`RVVI_IRQ_MASK) == '0)
      else $error("interrupt level outside implemented mask");

   // change flags move only with a retirement
   csrWbOnRetire: assert property (@(posedge rvvi) disable iff (!rstN_i)
      !$stable(csrWb_i) |-> retireValid_i)
      else $error("csr change flags moved without a retirement");

   // halt released by a retirement
   haltFallOnRetire: assert property (@(posedge rvvi) disable iff (!rstN_i)
      $fell(haltReq_i) |-> retireValid_i)
      else $error("halt request fell without a retirement");

   // cause only reloads at a retirement
   nmiCauseHeld: assert property (@(posedge rvvi) disable iff (!rstN_i)
      (nmi_i && $past(nmi_i) && !retireValid_i) |-> $stable(nmiCause_i))
      else $error("nmi cause changed while nmi held");

endmodule

bind rvfiRvviBridge rvfiRvviBridge_assertions i_rvfiRvviBridge_assertions (
   .rvvi          (rvvi),
   .rstN_i        (rstN_i),
   .retireValid_i (retireValid_o),
   .csrWb_i       (csrWb_o),
   .irqLevel_i    (irqLevel_o),
   .haltReq_i     (haltReq_o),
   .nmi_i         (nmi_o),
   .nmiCause_i    (nmiCause_o)
);

//--- dv/rvfiRvviBridge_tb.sv
// bridge testbench with clock, reset, stimulus table, row loop and value check
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module rvfiRvviBridge_tb;

   import rvviTracePkg::*;

   localparam int unsigned seedValue    = 32'h2627_476d;
   localparam int          resetCycles  = 10;
   localparam int          resetTimeout = 50;
   localparam rvfiTrap_t   noTrap       = '0;
   localparam rvfiIntr_t   noIntr       = '0;

   // inputs of one row
   typedef struct packed {
      logic                               valid;
      rvfiRetire_t                        rvfi;
      logic [1:0]                         nmip;
      csrPort_t [`RVVI_NUM_CSR-1:0]       csr;
      irqVec_t                            irq;
      logic                               debugReq;
   } stim_t;

   // registered outputs after the row's rising edge
   typedef struct packed {
      logic                               retireValid;
      rvfiRetire_t                        trace;
      rvviGpr_t                           gpr;
      xlen_t [`RVVI_NUM_CSR-1:0]          csrValue;
      logic [`RVVI_NUM_CSR-1:0]           csrWb;
      irqVec_t                            irqLevel;
      logic                               haltReq;
      logic                               nmi;
      intrCause_t                         nmiCause;
      logic                               instrBusFault;
   } expect_t;

   logic                               rvvi = 1'b0;
   logic                               rstN;
   logic                               rvfiValid;
   rvfiRetire_t                        rvfi;
   logic [1:0]                         rvfiNmip;
   csrPort_t [`RVVI_NUM_CSR-1:0]       csr;
   irqVec_t                            irq;
   logic                               debugReq;
   logic                               retireValid;
   rvfiRetire_t                        trace;
   rvviGpr_t                           gpr;
   xlen_t [`RVVI_NUM_CSR-1:0]          csrValue;
   logic [`RVVI_NUM_CSR-1:0]           csrWb;
   irqVec_t                            irqLevel;
   logic                               haltReq;
   logic                               nmi;
   intrCause_t                         nmiCause;
   logic                               instrBusFault;

   // table under construction and model state
   stim_t       cur;
   expect_t     model;
   stim_t       stimTab[$];
   expect_t     expTab[$];
   int          curRow;
   int unsigned seedDummy;

   ////////////////////////////////////////////////////////////////////////////
   // clock, reset, DUT
   ////////////////////////////////////////////////////////////////////////////

   // 8 ns period
   always #4 rvvi = ~rvvi;

   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge rvvi);
      @(negedge rvvi);
      rstN = 1'b1;
   end

   rvfiRvviBridge i_rvfiRvviBridge (
      .rvvi            (rvvi),
      .rstN_i          (rstN),
      .rvfiValid_i     (rvfiValid),
      .rvfi_i          (rvfi),
      .rvfiNmip_i      (rvfiNmip),
      .csr_i           (csr),
      .irq_i           (irq),
      .debugReq_i      (debugReq),
      .retireValid_o   (retireValid),
      .trace_o         (trace),
      .gpr_o           (gpr),
      .csrValue_o      (csrValue),
      .csrWb_o         (csrWb),
      .irqLevel_o      (irqLevel),
      .haltReq_o       (haltReq),
      .nmi_o           (nmi),
      .nmiCause_o      (nmiCause),
      .instrBusFault_o (instrBusFault)
   );

   ////////////////////////////////////////////////////////////////////////////
   // expected values
   ////////////////////////////////////////////////////////////////////////////

   // advance the model by one rising edge with cur applied and store the row
   task automatic addRow();
      xlen_t   merged [`RVVI_NUM_CSR];
      irqVec_t causeBit;
      irqVec_t nextIrq;
      logic    nmiEntry;
      logic    nmiHit;
      // write data under the mask and read data elsewhere
      for (int k = 0; k < `RVVI_NUM_CSR; k++) begin
         for (int b = 0; b < `RVVI_XLEN; b++) begin
            merged[k][b] = cur.csr[k].wmask[b] ? cur.csr[k].wdata[b] : cur.csr[k].rdata[b];
         end
      end
      causeBit = '0;
      if (cur.valid && cur.rvfi.intr.interrupt) begin
         causeBit[cur.rvfi.intr.cause[4:0]] = 1'b1;
      end
      nextIrq = (merged[`RVVI_CSR_MIP] | causeBit) & `RVVI_IRQ_MASK;
      // rise on any edge and fall only on a retirement
      for (int b = 0; b < `RVVI_XLEN; b++) begin
         if (!model.irqLevel[b]) begin
            model.irqLevel[b] = nextIrq[b];
         end else if (cur.valid && (!nextIrq[b] || !cur.irq[b])) begin
            model.irqLevel[b] = 1'b0;
         end
      end
      if (cur.debugReq) begin
         model.haltReq = 1'b1;
      end else if (cur.valid) begin
         model.haltReq = 1'b0;
      end
      model.retireValid = cur.valid;
      if (cur.valid) begin
         model.trace     = cur.rvfi;
         model.gpr.wdata = cur.rvfi.rdWdata;
         model.gpr.wb    = '0;
         if (cur.rvfi.rdAddr != '0) begin
            model.gpr.wb[cur.rvfi.rdAddr] = 1'b1;
         end
         for (int k = 0; k < `RVVI_NUM_CSR; k++) begin
            model.csrWb[k]    = (merged[k] != model.csrValue[k]);
            model.csrValue[k] = merged[k];
         end
         nmiEntry = cur.rvfi.intr.intr && cur.rvfi.intr.interrupt &&
                    ((cur.rvfi.intr.cause == `RVVI_NMI_LOAD_CAUSE) ||
                     (cur.rvfi.intr.cause == `RVVI_NMI_STORE_CAUSE));
         nmiHit = nmiEntry || cur.nmip[0];
         model.nmi = nmiHit;
         // bit 1 selects store for a pending-only nmi
         if (nmiHit) begin
            model.nmiCause = nmiEntry ? cur.rvfi.intr.cause :
                             (cur.nmip[1] ? `RVVI_NMI_STORE_CAUSE : `RVVI_NMI_LOAD_CAUSE);
         end
         model.instrBusFault = cur.rvfi.trap.trap && cur.rvfi.trap.exception &&
                               (cur.rvfi.trap.excCause == `RVVI_FETCH_FAULT_CAUSE);
      end
      stimTab.push_back(cur);
      expTab.push_back(model);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // row builders
   ////////////////////////////////////////////////////////////////////////////

   function automatic rvfiRetire_t randRetire(input gprAddr_t rd);
      rvfiRetire_t r;
      r         = '0;
      r.order   = {$urandom, $urandom};
      r.insn    = $urandom;
      r.pcRdata = $urandom;
      r.pcWdata = r.pcRdata + 32'd4;
      r.mode    = 2'b11;
      r.rdAddr  = rd;
      r.rdWdata = $urandom;
      return r;
   endfunction

   function automatic gprAddr_t randRd();
      return gprAddr_t'($urandom_range(31, 1));
   endfunction

   function automatic rvfiIntr_t mkIntr(input intrCause_t c);
      rvfiIntr_t i;
      i           = '0;
      i.intr      = 1'b1;
      i.interrupt = 1'b1;
      i.cause     = c;
      return i;
   endfunction

   function automatic rvfiTrap_t mkTrap(input excCause_t c);
      rvfiTrap_t t;
      t           = '0;
      t.trap      = 1'b1;
      t.exception = 1'b1;
      t.excCause  = c;
      return t;
   endfunction

   task automatic shuffleCsr(input int k);
      cur.csr[k].rdata = $urandom;
      cur.csr[k].wdata = $urandom;
      cur.csr[k].wmask = $urandom;
   endtask

   task automatic setMip(input xlen_t rdata, input xlen_t wdata, input xlen_t wmask);
      cur.csr[`RVVI_CSR_MIP].rdata = rdata;
      cur.csr[`RVVI_CSR_MIP].wdata = wdata;
      cur.csr[`RVVI_CSR_MIP].wmask = wmask;
   endtask

   task automatic retireRow(input gprAddr_t rd, input rvfiTrap_t trap, input rvfiIntr_t intr);
      cur.valid     = 1'b1;
      cur.rvfi      = randRetire(rd);
      cur.rvfi.trap = trap;
      cur.rvfi.intr = intr;
      addRow();
   endtask

   // fresh rvfi fields that the held trace must not pick up
   task automatic idleRow();
      cur.valid = 1'b0;
      cur.rvfi  = randRetire(randRd());
      addRow();
   endtask

   task automatic buildTable();
      cur   = '0;
      model = '0;
      cur.irq = '1;
      // trace, gpr decode, csr flags
      for (int k = 0; k < `RVVI_CSR_MIP; k++) begin
         shuffleCsr(k);
      end
      retireRow(5'd5, noTrap, noIntr);
      idleRow();
      // x0 write with repeated csrs gives no flags
      retireRow(5'd0, noTrap, noIntr);
      shuffleCsr(`RVVI_CSR_MTVEC);
      shuffleCsr(`RVVI_CSR_MEPC);
      retireRow(5'd31, noTrap, noIntr);
      retireRow(5'd1, noTrap, noIntr);
      // mip bits 5 and 7 where only 7 is implemented
      setMip(32'h0000_00A0, '0, '0);
      idleRow();
      retireRow(randRd(), noTrap, mkIntr(11'd11));
      // level 7 waits for a retirement after irq 7 drops
      cur.irq = ~32'h0000_0080;
      idleRow();
      retireRow(randRd(), noTrap, noIntr);
      cur.irq = '1;
      setMip('0, 32'h0001_0000, 32'h0001_0000);
      retireRow(randRd(), noTrap, noIntr);
      setMip('0, '0, '0);
      retireRow(randRd(), noTrap, noIntr);
      // halt request
      cur.debugReq = 1'b1;
      idleRow();
      cur.debugReq = 1'b0;
      idleRow();
      idleRow();
      retireRow(randRd(), noTrap, noIntr);
      cur.debugReq = 1'b1;
      retireRow(randRd(), noTrap, noIntr);
      cur.debugReq = 1'b0;
      retireRow(randRd(), noTrap, noIntr);
      // nmi by handler entry, then by pending bits
      retireRow(randRd(), noTrap, mkIntr(`RVVI_NMI_LOAD_CAUSE));
      retireRow(randRd(), noTrap, mkIntr(`RVVI_NMI_STORE_CAUSE));
      // level and cause hold between retirements
      idleRow();
      retireRow(randRd(), noTrap, noIntr);
      // pending bit alone waits for a retirement
      cur.nmip = 2'b01;
      idleRow();
      retireRow(randRd(), noTrap, noIntr);
      cur.nmip = 2'b11;
      retireRow(randRd(), noTrap, noIntr);
      cur.nmip = 2'b00;
      retireRow(randRd(), noTrap, noIntr);
      idleRow();
      // fetch fault, then a near miss on the cause
      retireRow(randRd(), mkTrap(`RVVI_FETCH_FAULT_CAUSE), noIntr);
      idleRow();
      retireRow(randRd(), noTrap, noIntr);
      retireRow(randRd(), mkTrap(6'd47), noIntr);
      // back-to-back retirements
      for (int i = 0; i < 8; i++) begin
         shuffleCsr($urandom_range(6, 0));
         retireRow(randRd(), noTrap, noIntr);
      end
      idleRow();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // drive and check
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [255:0] actual,
                             input logic [255:0] expected);
      if (actual !== expected) begin
         $display("ERROR: time %0t row %0d %s: actual %0h, expected %0h",
                  $time, curRow, name, actual, expected);
         $display("Test failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic applyRow(input int r);
      rvfiValid = stimTab[r].valid;
      rvfi      = stimTab[r].rvfi;
      rvfiNmip  = stimTab[r].nmip;
      csr       = stimTab[r].csr;
      irq       = stimTab[r].irq;
      debugReq  = stimTab[r].debugReq;
   endtask

   task automatic checkRow(input int r);
      expect_t e;
      e = expTab[r];
      checkValue("retireValid_o", 256'(retireValid), 256'(e.retireValid));
      checkValue("trace_o", 256'(trace), 256'(e.trace));
      checkValue("gpr_o", 256'(gpr), 256'(e.gpr));
      checkValue("csrValue_o", 256'(csrValue), 256'(e.csrValue));
      checkValue("csrWb_o", 256'(csrWb), 256'(e.csrWb));
      checkValue("irqLevel_o", 256'(irqLevel), 256'(e.irqLevel));
      checkValue("haltReq_o", 256'(haltReq), 256'(e.haltReq));
      checkValue("nmi_o", 256'(nmi), 256'(e.nmi));
      checkValue("nmiCause_o", 256'(nmiCause), 256'(e.nmiCause));
      checkValue("instrBusFault_o", 256'(instrBusFault), 256'(e.instrBusFault));
   endtask

   task automatic waitReset();
      int cycles;
      cycles = 0;
      while (rstN !== 1'b1) begin
         @(negedge rvvi);
         cycles++;
         if (cycles > resetTimeout) begin
            $display("reset was not released within %0d cycles", resetTimeout);
            $display("Test failed");
            $fatal(1, "reset timeout");
         end
      end
   endtask

   initial begin
      seedDummy = $urandom(seedValue);
      rvfiValid = 1'b0;
      rvfi      = '0;
      rvfiNmip  = '0;
      csr       = '0;
      irq       = '0;
      debugReq  = 1'b0;
      curRow    = 0;
      buildTable();
      waitReset();
      // one rising edge per row and its check at the following falling edge
      for (int r = 0; r < stimTab.size(); r++) begin
         curRow = r;
         applyRow(r);
         @(negedge rvvi);
         checkRow(r);
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+rtl
rtl/rvviTracePkg.sv
rtl/bridgeCtrl.sv
rtl/csrMerge.sv
rtl/retireTrace.sv
rtl/irqTracker.sv
rtl/rvfiRvviBridge.sv
dv/rvfiRvviBridge_assertions.sv
dv/rvfiRvviBridge_tb.sv

//--- rtl/bridgeCtrl.sv
// control block: retire strobe, halt request, NMI FSM, fetch fault level
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module bridgeCtrl (
   input  logic                     rvvi,
   input  logic                     rstN_i,
   input  logic                     rvfiValid_i,
   input  rvviTracePkg::rvfiTrap_t  trap_i,
   input  rvviTracePkg::rvfiIntr_t  intr_i,
   input  logic [1:0]               rvfiNmip_i,
   input  logic                     debugReq_i,
   output logic                     retireStb_o,
   output logic                     haltReq_o,
   output logic                     nmi_o,
   output rvviTracePkg::intrCause_t nmiCause_o,
   output logic                     instrBusFault_o
);

   import rvviTracePkg::*;

   nmiState_t  nmiState;
   nmiState_t  nmiNext;
   logic       nmiIntr;
   logic       nmiCond;
   intrCause_t nmiCauseNext;
   logic       fetchFault;

   // one retirement per valid cycle, no back-pressure
   assign retireStb_o = rvfiValid_i;

   ////////////////////////////////////////////////////////////////////////////
   // halt request
   ////////////////////////////////////////////////////////////////////////////

   // set on any debug request
   // released only when an instruction retires without it
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         haltReq_o <= 1'b0;
      end else if (debugReq_i) begin
         haltReq_o <= 1'b1;
      end else if (retireStb_o) begin
         haltReq_o <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // NMI on load / store bus error
   ////////////////////////////////////////////////////////////////////////////

   // handler entry with an nmi cause
   assign nmiIntr = intr_i.intr && intr_i.interrupt &&
                    ((intr_i.cause == `RVVI_NMI_LOAD_CAUSE) ||
                     (intr_i.cause == `RVVI_NMI_STORE_CAUSE));

   // or pending nmi reported by the core
   assign nmiCond = nmiIntr || rvfiNmip_i[0];

   // pending-only case: bit 1 tells store from load
   assign nmiCauseNext = nmiIntr       ? intr_i.cause :
                         rvfiNmip_i[1] ? `RVVI_NMI_STORE_CAUSE : `RVVI_NMI_LOAD_CAUSE;

   always_comb begin
      nmiNext = nmiState;
      case (nmiState)
         nmiIdle: begin
            if (retireStb_o && nmiCond) begin
               nmiNext = nmiActive;
            end
         end
         nmiActive: begin
            // clean retirement drops the level
            if (retireStb_o && !nmiCond) begin
               nmiNext = nmiIdle;
            end
         end
         default: nmiNext = nmiIdle;
      endcase
   end

   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         nmiState   <= nmiIdle;
         nmiCause_o <= '0;
      end else begin
         nmiState <= nmiNext;
         if (retireStb_o && nmiCond) begin
            nmiCause_o <= nmiCauseNext;
         end
      end
   end

   assign nmi_o = (nmiState == nmiActive);

   ////////////////////////////////////////////////////////////////////////////
   // instruction bus fault
   ////////////////////////////////////////////////////////////////////////////

   assign fetchFault = trap_i.trap && trap_i.exception &&
                       (trap_i.excCause == `RVVI_FETCH_FAULT_CAUSE);

   // follows each retirement, held in between
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         instrBusFault_o <= 1'b0;
      end else if (retireStb_o) begin
         instrBusFault_o <= fetchFault;
      end
   end

endmodule

//--- rtl/csrMerge.sv
// CSR merge from rvfi read/write/mask and per-CSR change flags
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module csrMerge (
   input  logic                                      rvvi,
   input  logic                                      rstN_i,
   input  logic                                      retireStb_i,
   input  rvviTracePkg::csrPort_t [`RVVI_NUM_CSR-1:0] csr_i,
   output rvviTracePkg::xlen_t    [`RVVI_NUM_CSR-1:0] csrValue_o,
   output logic                   [`RVVI_NUM_CSR-1:0] csrWb_o,
   output rvviTracePkg::xlen_t                        mipNow_o
);

   import rvviTracePkg::*;

   xlen_t [`RVVI_NUM_CSR-1:0] merged;
   logic  [`RVVI_NUM_CSR-1:0] changed;

   ////////////////////////////////////////////////////////////////////////////
   // merge
   ////////////////////////////////////////////////////////////////////////////

   // masked bits from write data, the rest from read data
   always_comb begin
      for (int k = 0; k < `RVVI_NUM_CSR; k++) begin
         merged[k]  = (csr_i[k].wdata & csr_i[k].wmask) |
                      (csr_i[k].rdata & ~csr_i[k].wmask);
         // against the value held since last retirement
         changed[k] = (merged[k] != csrValue_o[k]);
      end
   end

   // live mip for the interrupt tracker, every cycle
   assign mipNow_o = merged[`RVVI_CSR_MIP];

   ////////////////////////////////////////////////////////////////////////////
   // retirement snapshot
   ////////////////////////////////////////////////////////////////////////////

   // reset value doubles as the reference before the first retirement
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         csrValue_o <= '0;
         csrWb_o    <= '0;
      end else if (retireStb_i) begin
         csrValue_o <= merged;
         csrWb_o    <= changed;
      end
   end

endmodule

//--- rtl/irqTracker.sv
// per-bit interrupt level tracking from mip and retired interrupt cause
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module irqTracker (
   input  logic                    rvvi,
   input  logic                    rstN_i,
   input  logic                    retireStb_i,
   input  rvviTracePkg::rvfiIntr_t intr_i,
   input  rvviTracePkg::xlen_t     mip_i,
   input  rvviTracePkg::irqVec_t   irq_i,
   output rvviTracePkg::irqVec_t   irqLevel_o
);

   import rvviTracePkg::*;

   irqVec_t causeBit;
   irqVec_t irqNext;
   irqVec_t setBits;
   irqVec_t clrBits;

   ////////////////////////////////////////////////////////////////////////////
   // next vector
   ////////////////////////////////////////////////////////////////////////////

   // taken interrupt marks its own bit, only on a retirement
   always_comb begin
      causeBit = '0;
      if (retireStb_i && intr_i.interrupt) begin
         causeBit = irqVec_t'(1) << intr_i.cause[4:0];
      end
   end

   // unimplemented bits never reach the levels
   assign irqNext = (mip_i | causeBit) & `RVVI_IRQ_MASK;

   ////////////////////////////////////////////////////////////////////////////
   // set / clear
   ////////////////////////////////////////////////////////////////////////////

   // rise at any edge
   assign setBits = ~irqLevel_o & irqNext;

   // fall only when an instruction retires
   // either pending gone or core input dropped
   always_comb begin
      clrBits = '0;
      if (retireStb_i) begin
         clrBits = irqLevel_o & (~irqNext | ~irq_i);
      end
   end

   // set and clear never overlap, set needs level 0
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         irqLevel_o <= '0;
      end else begin
         irqLevel_o <= (irqLevel_o | setBits) & ~clrBits;
      end
   end

endmodule

//--- rtl/retireTrace.sv
// retirement trace register and GPR write-back decode
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module retireTrace (
   input  logic                      rvvi,
   input  logic                      rstN_i,
   input  logic                      retireStb_i,
   input  rvviTracePkg::rvfiRetire_t rvfi_i,
   output logic                      retireValid_o,
   output rvviTracePkg::rvfiRetire_t trace_o,
   output rvviTracePkg::rvviGpr_t    gpr_o
);

   import rvviTracePkg::*;

   rvviGpr_t gprNext;

   ////////////////////////////////////////////////////////////////////////////
   // gpr write-back
   ////////////////////////////////////////////////////////////////////////////

   // one-hot at rd
   // x0 never written, so no mask bit for it
   always_comb begin
      gprNext.wdata = rvfi_i.rdWdata;
      if (rvfi_i.rdAddr == '0) begin
         gprNext.wb = '0;
      end else begin
         gprNext.wb = gprMask_t'(1) << rvfi_i.rdAddr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers
   ////////////////////////////////////////////////////////////////////////////

   // valid pulse, one cycle per retirement
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         retireValid_o <= 1'b0;
      end else begin
         retireValid_o <= retireStb_i;
      end
   end

   // trace fields and gpr hold the last retirement
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         trace_o <= '0;
         gpr_o   <= '0;
      end else if (retireStb_i) begin
         trace_o <= rvfi_i;
         gpr_o   <= gprNext;
      end
   end

endmodule

//--- rtl/rvfiRvviBridge.sv
// RVFI to RVVI bridge top: control, CSR merge, trace and interrupt blocks
`timescale 1ns/1ps
`include "rvviTrace_macros.svh"

module rvfiRvviBridge (
   input  logic                                      rvvi,
   input  logic                                      rstN_i,
   // rvfi retirement
   input  logic                                      rvfiValid_i,
   input  rvviTracePkg::rvfiRetire_t                 rvfi_i,
   input  logic [1:0]                                rvfiNmip_i,
   input  rvviTracePkg::csrPort_t [`RVVI_NUM_CSR-1:0] csr_i,
   // core side async inputs
   input  rvviTracePkg::irqVec_t                     irq_i,
   input  logic                                      debugReq_i,
   // trace
   output logic                                      retireValid_o,
   output rvviTracePkg::rvfiRetire_t                 trace_o,
   output rvviTracePkg::rvviGpr_t                    gpr_o,
   output rvviTracePkg::xlen_t    [`RVVI_NUM_CSR-1:0] csrValue_o,
   output logic                   [`RVVI_NUM_CSR-1:0] csrWb_o,
   // levels for the reference model
   output rvviTracePkg::irqVec_t                     irqLevel_o,
   output logic                                      haltReq_o,
   output logic                                      nmi_o,
   output rvviTracePkg::intrCause_t                  nmiCause_o,
   output logic                                      instrBusFault_o
);

   import rvviTracePkg::*;

   logic      retireStb;
   xlen_t     mipNow;
   rvfiTrap_t rvfiTrap;
   rvfiIntr_t rvfiIntr;

   // trap and intr fields feed control and irq blocks
   assign rvfiTrap = rvfi_i.trap;
   assign rvfiIntr = rvfi_i.intr;

   ////////////////////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////////////////////

   bridgeCtrl i_bridgeCtrl (
      .rvvi            (rvvi),
      .rstN_i          (rstN_i),
      .rvfiValid_i     (rvfiValid_i),
      .trap_i          (rvfiTrap),
      .intr_i          (rvfiIntr),
      .rvfiNmip_i      (rvfiNmip_i),
      .debugReq_i      (debugReq_i),
      .retireStb_o     (retireStb),
      .haltReq_o       (haltReq_o),
      .nmi_o           (nmi_o),
      .nmiCause_o      (nmiCause_o),
      .instrBusFault_o (instrBusFault_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // datapath
   ////////////////////////////////////////////////////////////////////////////

   csrMerge i_csrMerge (
      .rvvi        (rvvi),
      .rstN_i      (rstN_i),
      .retireStb_i (retireStb),
      .csr_i       (csr_i),
      .csrValue_o  (csrValue_o),
      .csrWb_o     (csrWb_o),
      .mipNow_o    (mipNow)
   );

   retireTrace i_retireTrace (
      .rvvi          (rvvi),
      .rstN_i        (rstN_i),
      .retireStb_i   (retireStb),
      .rvfi_i        (rvfi_i),
      .retireValid_o (retireValid_o),
      .trace_o       (trace_o),
      .gpr_o         (gpr_o)
   );

   // uses live mip, not the registered snapshot
   irqTracker i_irqTracker (
      .rvvi        (rvvi),
      .rstN_i      (rstN_i),
      .retireStb_i (retireStb),
      .intr_i      (rvfiIntr),
      .mip_i       (mipNow),
      .irq_i       (irq_i),
      .irqLevel_o  (irqLevel_o)
   );

endmodule

//--- rtl/rvviTracePkg.sv
// trace vector typedefs, retirement and CSR structs, NMI state enum
`include "rvviTrace_macros.svh"

package rvviTracePkg;

   ////////////////////////////////////////////////////////////////////////////
   // plain vectors
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [`RVVI_XLEN-1:0]         xlen_t;
   typedef logic [`RVVI_GPR_ADDR_W-1:0]   gprAddr_t;
   // one bit per gpr
   typedef logic [`RVVI_XLEN-1:0]         gprMask_t;
   // one level per mip bit
   typedef logic [`RVVI_XLEN-1:0]         irqVec_t;
   typedef logic [`RVVI_EXC_CAUSE_W-1:0]  excCause_t;
   typedef logic [`RVVI_INTR_CAUSE_W-1:0] intrCause_t;
   typedef logic [`RVVI_ORDER_W-1:0]      order_t;

   ////////////////////////////////////////////////////////////////////////////
   // rvfi side
   ////////////////////////////////////////////////////////////////////////////

   // trap info of the retired instruction
   typedef struct packed {
      logic      trap;
      logic      exception;
      logic      debug;
      excCause_t excCause;
   } rvfiTrap_t;

   // first instruction of a trap handler
   typedef struct packed {
      logic       intr;
      logic       exception;
      logic       interrupt;
      intrCause_t cause;
   } rvfiIntr_t;

   // one retirement
   typedef struct packed {
      order_t                  order;
      xlen_t                   insn;
      xlen_t                   pcRdata;
      xlen_t                   pcWdata;
      rvfiTrap_t               trap;
      rvfiIntr_t               intr;
      logic [`RVVI_MODE_W-1:0] mode;
      gprAddr_t                rdAddr;
      xlen_t                   rdWdata;
   } rvfiRetire_t;

   // per-CSR rvfi view, merged as (wdata & wmask) | (rdata & ~wmask)
   typedef struct packed {
      xlen_t rdata;
      xlen_t wdata;
      xlen_t wmask;
   } csrPort_t;

   ////////////////////////////////////////////////////////////////////////////
   // rvvi side
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      gprMask_t wb;
      xlen_t    wdata;
   } rvviGpr_t;

   typedef enum logic [0:0] {
      nmiIdle   = 1'b0,
      nmiActive = 1'b1
   } nmiState_t;

endpackage

//--- rtl/rvviTrace_macros.svh
// trace widths, tracked CSR indices, interrupt mask and cause constants
`ifndef RVVI_TRACE_MACROS_SVH
`define RVVI_TRACE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

// integer register and CSR width
`define RVVI_XLEN          32
// retirement order counter
`define RVVI_ORDER_W       64
// gpr index
`define RVVI_GPR_ADDR_W    5
// synchronous exception cause in the trap field
`define RVVI_EXC_CAUSE_W   6
// interrupt cause in the intr field
`define RVVI_INTR_CAUSE_W  11
// privilege mode
`define RVVI_MODE_W        2

////////////////////////////////////////////////////////////////////////////
// tracked CSR set
////////////////////////////////////////////////////////////////////////////

`define RVVI_NUM_CSR       8
`define RVVI_CSR_MSTATUS   0
`define RVVI_CSR_MIE       1
`define RVVI_CSR_MTVEC     2
`define RVVI_CSR_MSCRATCH  3
`define RVVI_CSR_MEPC      4
`define RVVI_CSR_MCAUSE    5
`define RVVI_CSR_MTVAL     6
`define RVVI_CSR_MIP       7

////////////////////////////////////////////////////////////////////////////
// interrupts and causes
////////////////////////////////////////////////////////////////////////////

// msw 3, mtimer 7, mext 11, local 16..31
`define RVVI_IRQ_MASK          32'hFFFF_0888
// nmi on load or store bus error
`define RVVI_NMI_LOAD_CAUSE    11'd1024
`define RVVI_NMI_STORE_CAUSE   11'd1025
// instruction fetch bus fault
`define RVVI_FETCH_FAULT_CAUSE 6'd48

`endif
